// File: src/uart_scrambler_pkg.sv
//**************************************************
// Shared constants for the scrambling UART host
// Frame format, baud divider, key and FSM encoding
//**************************************************
`default_nettype none

package uart_scrambler_pkg;

    // Frame format, 8N1
    localparam int DATA_BITS = 8;
    localparam int BIT_CNT_W = 4;              // Counts data bits 0..7

    // Bit period in clocks, short for simulation
    localparam int BAUD_DIV   = 16;
    localparam int BAUD_CNT_W = 16;

    // Key register and folded keystream word
    localparam int KEY_W  = 128;
    localparam int LOAD_W = 64;                // Half the key width

    // Fixed key seed loaded at reset
    localparam logic [KEY_W-1:0] KEY_INIT =
        128'hAAF1_0123_4567_89AB_CDEF_AAF1_0123_4567;

    // One-hot FSM states used by both tx and rx
    localparam int ST_W = 4;
    localparam logic [ST_W-1:0] ST_IDLE  = 4'b0001;
    localparam logic [ST_W-1:0] ST_START = 4'b0010;
    localparam logic [ST_W-1:0] ST_DATA  = 4'b0100;
    localparam logic [ST_W-1:0] ST_STOP  = 4'b1000;

endpackage

`default_nettype wire

// File: src/baud_tick_gen.sv
//**************************************************
// Baud tick generator
// Free-running divider, one-cycle tick per bit period
//**************************************************
`default_nettype none

module baud_tick_gen (
    input  logic clk,
    input  logic rst,
    output logic baud_tick
);
    import uart_scrambler_pkg::*;

    logic [BAUD_CNT_W-1:0] cnt;

    // Wraps after BAUD_DIV counts
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt == BAUD_CNT_W'(BAUD_DIV - 1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign baud_tick = (cnt == '0);            // Tick decoded at count zero

    // Ticks are at least one full bit period apart
    a_tick_spacing: assert property (
        @(posedge clk) disable iff (rst)
        baud_tick |=> !baud_tick [* BAUD_DIV - 1]
    );

endmodule

`default_nettype wire

// File: src/key_schedule.sv
//**************************************************
// Key schedule and keystream
// Byte-wise key shift with transmit data mixing
//**************************************************
`default_nettype none

module key_schedule (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 tx_start,
    input  logic                                 rx_ready,
    input  logic [uart_scrambler_pkg::DATA_BITS-1:0] tx_data,
    output logic [uart_scrambler_pkg::LOAD_W-1:0]    load
);
    import uart_scrambler_pkg::*;

    logic [KEY_W-1:0]     key;
    logic                 key_step;
    logic [DATA_BITS-1:0] top_byte;
    logic [LOAD_W-1:0]    fold;

    // Step on any transmit strobe, busy or not, and on each received byte
    assign key_step = tx_start | rx_ready;
    assign top_byte = key[KEY_W-1 -: DATA_BITS];

    // Upper half folded onto lower half
    assign fold = key[KEY_W-1:LOAD_W] ^ key[LOAD_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key <= KEY_INIT;
        end else if (key_step) begin
            // Shift left one byte, old top byte mixed back in at the bottom
            key <= {key[KEY_W-DATA_BITS-1:0], top_byte ^ tx_data};
        end
    end

    // Keystream register, trails the key by one edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load <= KEY_INIT[KEY_W-1:LOAD_W] ^ KEY_INIT[LOAD_W-1:0];
        end else begin
            load <= fold;
        end
    end

    // Key only moves on a strobe
    a_key_hold: assert property (
        @(posedge clk) disable iff (rst)
        !key_step |=> $stable(key)
    );

endmodule

`default_nettype wire

// File: src/uart_tx.sv
//**************************************************
// UART transmitter
// Scrambles one byte per start strobe and sends it 8N1
//**************************************************
`default_nettype none

module uart_tx (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     baud_tick,
    input  logic                                     tx_start,
    input  logic [uart_scrambler_pkg::DATA_BITS-1:0] tx_data,
    input  logic [uart_scrambler_pkg::LOAD_W-1:0]    load,
    output logic                                     tx_out,
    output logic                                     tx_busy
);
    import uart_scrambler_pkg::*;

    logic [ST_W-1:0]      state;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [DATA_BITS-1:0] shift;
    logic                 accept;
    logic                 last_bit;

    // Start honoured only when idle and no longer flagged busy
    assign accept   = (state == ST_IDLE) && !tx_busy && tx_start;
    assign last_bit = (bit_cnt == BIT_CNT_W'(DATA_BITS - 1));

    // Payload, scrambled with the keystream low byte on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            shift <= tx_data ^ load[DATA_BITS-1:0];
        end else if ((state == ST_DATA) && baud_tick) begin
            shift <= shift >> 1;               // LSB first
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            tx_out  <= 1'b1;
            tx_busy <= 1'b0;
            bit_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    tx_out  <= 1'b1;
                    tx_busy <= accept;
                    if (accept) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    if (baud_tick) begin
                        tx_out  <= 1'b0;       // Start bit
                        bit_cnt <= '0;
                        state   <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (baud_tick) begin
                        tx_out <= shift[0];
                        if (last_bit) begin
                            state <= ST_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ST_STOP: begin
                    if (baud_tick) begin
                        tx_out <= 1'b1;        // Stop bit, busy drops next cycle
                        state  <= ST_IDLE;
                    end
                end
                default: begin
                    state   <= ST_IDLE;
                    tx_out  <= 1'b1;
                    tx_busy <= 1'b0;
                end
            endcase
        end
    end

    a_idle_line_high: assert property (
        @(posedge clk) disable iff (rst) (state == ST_IDLE) |-> tx_out
    );

    a_busy_low_idle: assert property (
        @(posedge clk) disable iff (rst) !tx_busy |-> (state == ST_IDLE)
    );

    a_state_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(state));

endmodule

`default_nettype wire

// File: src/uart_rx.sv
//**************************************************
// UART receiver
// Deserializes 8N1 frames into a byte and ready pulse
//**************************************************
`default_nettype none

module uart_rx (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     baud_tick,
    input  logic                                     rx_in,
    output logic [uart_scrambler_pkg::DATA_BITS-1:0] rx_data,
    output logic                                     rx_ready
);
    import uart_scrambler_pkg::*;

    logic                 rx_sync;
    logic [ST_W-1:0]      state;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [DATA_BITS-1:0] shift;
    logic                 last_bit;

    assign last_bit = (bit_cnt == BIT_CNT_W'(DATA_BITS - 1));

    // Single synchronizing flop, idles at line high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_sync <= 1'b1;
        end else begin
            rx_sync <= rx_in;
        end
    end

    // Data bits arrive LSB first, so fill from the top
    always_ff @(posedge clk) begin
        if ((state == ST_DATA) && baud_tick) begin
            shift <= {rx_sync, shift[DATA_BITS-1:1]};
        end
    end

    // Output byte, overwritten by every completed frame
    always_ff @(posedge clk) begin
        if ((state == ST_STOP) && baud_tick) begin
            rx_data <= shift;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            rx_ready <= 1'b0;
            bit_cnt  <= '0;
        end else begin
            rx_ready <= 1'b0;                  // Pulse only
            case (state)
                ST_IDLE: begin
                    if (!rx_sync) begin
                        state <= ST_START;     // Falling edge, start bit
                    end
                end
                ST_START: begin
                    if (baud_tick) begin
                        bit_cnt <= '0;
                        state   <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (baud_tick) begin
                        if (last_bit) begin
                            state <= ST_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ST_STOP: begin
                    if (baud_tick) begin
                        rx_ready <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // A frame takes many ticks, so ready can never repeat back to back
    a_ready_pulse: assert property (
        @(posedge clk) disable iff (rst) rx_ready |=> !rx_ready
    );

endmodule

`default_nettype wire

// File: src/uart_scrambler_top.sv
//**************************************************
// UART host with keyed transmit scrambler
//**************************************************
`default_nettype none

module uart_scrambler_top (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [uart_scrambler_pkg::DATA_BITS-1:0] tx_data,
    input  logic                                     tx_start,
    input  logic                                     rx_in,
    output logic [uart_scrambler_pkg::DATA_BITS-1:0] rx_data,
    output logic                                     tx_out,
    output logic                                     tx_busy,
    output logic                                     rx_ready
);
    import uart_scrambler_pkg::*;

    logic              baud_tick;              // Shared by tx and rx
    logic [LOAD_W-1:0] load;

    baud_tick_gen u_baud (
        .clk       (clk),
        .rst       (rst),
        .baud_tick (baud_tick)
    );

    // Key steps on raw start strobes and on received bytes
    key_schedule u_key (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .rx_ready (rx_ready),
        .tx_data  (tx_data),
        .load     (load)
    );

    uart_tx u_tx (
        .clk       (clk),
        .rst       (rst),
        .baud_tick (baud_tick),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .load      (load),
        .tx_out    (tx_out),
        .tx_busy   (tx_busy)
    );

    uart_rx u_rx (
        .clk       (clk),
        .rst       (rst),
        .baud_tick (baud_tick),
        .rx_in     (rx_in),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready)
    );

endmodule

`default_nettype wire

// File: dv/uart_checker.sv
//**************************************************
// Checker for the scrambling UART host
// Key and load model, tx frame decode, rx byte compare
//**************************************************
`default_nettype none

module uart_checker (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [uart_scrambler_pkg::DATA_BITS-1:0] tx_data,
    input  logic                                     tx_start,
    input  logic                                     rx_in,
    input  logic [uart_scrambler_pkg::DATA_BITS-1:0] rx_data,
    input  logic                                     tx_out,
    input  logic                                     tx_busy,
    input  logic                                     rx_ready,
    input  logic                                     end_of_test,
    output int                                       tx_err_cnt,
    output int                                       rx_err_cnt,
    output int                                       proto_err_cnt
);
    timeunit 1ns;
    timeprecision 100ps;
    import uart_scrambler_pkg::*;

    logic [KEY_W-1:0]     key_m;
    logic [LOAD_W-1:0]    load_m;
    logic [DATA_BITS-1:0] tx_exp_q[$];             // Scrambled bytes awaiting their frame
    logic [DATA_BITS-1:0] rx_exp_q[$];             // Bytes seen on rx_in awaiting rx_ready
    int                   proto_model = 0;
    int                   proto_tx = 0;
    int                   proto_rx = 0;
    int                   proto_end = 0;

    assign proto_err_cnt = proto_model + proto_tx + proto_rx + proto_end;

    function automatic logic [LOAD_W-1:0] fold_key(input logic [KEY_W-1:0] k);
        return k[KEY_W-1:LOAD_W] ^ k[LOAD_W-1:0];
    endfunction

    // Rest of the start bit plus the data bits, value taken at mid-bit
    task automatic read_frame(input bit use_tx, output logic [DATA_BITS-1:0] data,
                              output bit ok);
        logic line;
        logic level;
        ok    = 1'b1;
        level = 1'b0;                              // Start bit level
        data  = '0;
        for (int s = 1; s < (DATA_BITS + 1) * BAUD_DIV; s++) begin
            @(negedge clk);
            line = use_tx ? tx_out : rx_in;
            if (s % BAUD_DIV == 0) begin
                level = line;
            end else if (line !== level) begin
                ok = 1'b0;                         // Bit shorter than a bit period
            end
            if ((s >= BAUD_DIV) && (s % BAUD_DIV == BAUD_DIV / 2)) begin
                data = {line, data[DATA_BITS-1:1]};    // LSB first
            end
            if (use_tx && !tx_busy) begin
                ok = 1'b0;
            end
        end
    endtask

    task automatic check_stop(input bit use_tx, output bit ok);
        ok = 1'b1;
        repeat (BAUD_DIV) begin
            @(negedge clk);
            if ((use_tx ? tx_out : rx_in) !== 1'b1) begin
                ok = 1'b0;
            end
        end
    endtask

    // Falling edge sampling, inputs and registered outputs are both settled here
    initial begin : key_model
        logic [DATA_BITS-1:0] exp;
        bit                   stim_seen;
        bit                   not_idle;
        stim_seen  = 1'b0;
        rx_err_cnt = 0;
        forever begin
            @(negedge clk);
            not_idle = (tx_out !== 1'b1) || (tx_busy !== 1'b0) || (rx_ready !== 1'b0);
            if ((rst || !stim_seen) && not_idle) begin
                proto_model++;
                $display("Error at %0t: outputs not at idle levels after reset", $time);
            end
            if (rst) begin
                key_m  = KEY_INIT;
                load_m = fold_key(KEY_INIT);
            end else begin
                stim_seen = stim_seen | tx_start | !rx_in;
                if (tx_start && !tx_busy) begin
                    tx_exp_q.push_back(tx_data ^ load_m[DATA_BITS-1:0]);
                end
                if (rx_ready && rx_exp_q.size() == 0) begin
                    proto_model++;
                    $display("Error at %0t: rx_ready pulse with no frame pending", $time);
                end else if (rx_ready) begin
                    exp = rx_exp_q.pop_front();
                    if (rx_data !== exp) begin
                        rx_err_cnt++;
                        $display("mismatch at %0t: rx_data expected %02h got %02h",
                                 $time, exp, rx_data);
                    end
                end
                load_m = fold_key(key_m);          // Load trails the key by one edge
                if (tx_start || rx_ready) begin
                    key_m = {key_m[KEY_W-DATA_BITS-1:0],
                             key_m[KEY_W-1 -: DATA_BITS] ^ tx_data};
                end
            end
        end
    end

    initial begin : tx_monitor
        logic [DATA_BITS-1:0] got;
        logic [DATA_BITS-1:0] exp;
        bit                   ok;
        bit                   stop_ok;
        tx_err_cnt = 0;
        forever begin
            @(negedge clk);
            if (!rst && tx_out === 1'b0) begin
                read_frame(1'b1, got, ok);
                check_stop(1'b1, stop_ok);
                if (!ok || !stop_ok) begin
                    proto_tx++;
                    $display("Error at %0t: tx frame has a bad bit or lost tx_busy", $time);
                end
                if (tx_exp_q.size() == 0) begin
                    proto_tx++;
                    $display("Error at %0t: tx frame sent with no accepted start", $time);
                end else begin
                    exp = tx_exp_q.pop_front();
                    if (got !== exp) begin
                        tx_err_cnt++;
                        $display("mismatch at %0t: tx byte expected %02h decoded %02h",
                                 $time, exp, got);
                    end
                end
            end
        end
    end

    initial begin : rx_monitor
        logic [DATA_BITS-1:0] got;
        bit                   ok;
        forever begin
            @(negedge clk);
            if (!rst && rx_in === 1'b0) begin
                read_frame(1'b0, got, ok);
                if (rx_exp_q.size() != 0) begin
                    proto_rx++;
                    $display("Error at %0t: rx byte not delivered before next frame", $time);
                end
                rx_exp_q.push_back(got);
            end
        end
    end

    initial begin : end_check
        wait (end_of_test);
        if (tx_exp_q.size() != 0 || rx_exp_q.size() != 0) begin
            proto_end++;
            $display("Error at %0t: %0d tx and %0d rx bytes never came out",
                     $time, tx_exp_q.size(), rx_exp_q.size());
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_top.sv
//**************************************************
// Testbench for the scrambling UART host
// Random tx starts and rx frames from a fixed seed
//**************************************************
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import uart_scrambler_pkg::*;

    localparam int NUM_TX         = 40;
    localparam int NUM_RX         = 40;
    localparam int TIMEOUT_CYCLES = (NUM_TX + NUM_RX) * 12 * BAUD_DIV + 2000;
    localparam int RX_PHASE       = 8;         // Receiver then samples near mid-bit

    logic                 clk;
    logic                 rst;
    logic [DATA_BITS-1:0] tx_data;
    logic                 tx_start;
    logic                 rx_in;
    logic [DATA_BITS-1:0] rx_data;
    logic                 tx_out;
    logic                 tx_busy;
    logic                 rx_ready;
    logic                 end_of_test;
    int                   tx_err_cnt;
    int                   rx_err_cnt;
    int                   proto_err_cnt;
    int                   baud_phase;
    int                   cycle_cnt;
    int                   tx_accepted;
    int                   tx_ignored;
    int                   rx_sent;

    uart_scrambler_top dut (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .rx_in    (rx_in),
        .rx_data  (rx_data),
        .tx_out   (tx_out),
        .tx_busy  (tx_busy),
        .rx_ready (rx_ready)
    );

    uart_checker u_chk (
        .clk           (clk),
        .rst           (rst),
        .tx_data       (tx_data),
        .tx_start      (tx_start),
        .rx_in         (rx_in),
        .rx_data       (rx_data),
        .tx_out        (tx_out),
        .tx_busy       (tx_busy),
        .rx_ready      (rx_ready),
        .end_of_test   (end_of_test),
        .tx_err_cnt    (tx_err_cnt),
        .rx_err_cnt    (rx_err_cnt),
        .proto_err_cnt (proto_err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Bit period phase, the tick falls on edges where this reads zero
    always @(posedge clk or posedge rst) begin
        if (rst || baud_phase == BAUD_DIV - 1) begin
            baud_phase <= 0;
        end else begin
            baud_phase <= baud_phase + 1;
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the test did not finish", cycle_cnt);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic drive_tx();
        bit fire;
        while (tx_accepted < NUM_TX) begin
            @(posedge clk);
            #1;
            fire     = tx_busy ? ($urandom_range(63) == 0) : ($urandom_range(7) == 0);
            tx_start = fire;
            if (fire) begin
                tx_data = DATA_BITS'($urandom);
                if (tx_busy) begin
                    tx_ignored++;                  // Dropped, but the key still steps
                end else begin
                    tx_accepted++;
                end
            end
        end
        @(posedge clk);
        #1;
        tx_start = 1'b0;
    endtask

    task automatic send_frame(input logic [DATA_BITS-1:0] b);
        logic [DATA_BITS+1:0] frame;
        frame = {1'b1, b, 1'b0};                   // Stop, data, start
        for (int i = 0; i < DATA_BITS + 2; i++) begin
            rx_in = frame[i];
            repeat (BAUD_DIV) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic drive_rx();
        int idle_bits;
        while (rx_sent < NUM_RX) begin
            idle_bits = 2 + int'($urandom_range(2));
            repeat (idle_bits * BAUD_DIV) begin
                @(posedge clk);
                #1;
            end
            while (baud_phase != RX_PHASE) begin
                @(posedge clk);
                #1;
            end
            send_frame(DATA_BITS'($urandom));
            rx_sent++;
        end
    endtask

    initial begin
        void'($urandom(95));
        rst         = 1'b1;
        tx_start    = 1'b0;
        tx_data     = '0;
        rx_in       = 1'b1;
        end_of_test = 1'b0;
        tx_accepted = 0;
        tx_ignored  = 0;
        rx_sent     = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            drive_tx();
            drive_rx();
        join
        wait (!tx_busy);
        repeat (12 * BAUD_DIV) @(posedge clk);     // Drain last frames
        end_of_test = 1'b1;
        repeat (2) @(posedge clk);
        $display("errors tx=%0d rx=%0d protocol=%0d, tx frames %0d, ignored %0d, rx frames %0d",
                 tx_err_cnt, rx_err_cnt, proto_err_cnt, tx_accepted, tx_ignored, rx_sent);
        if (tx_err_cnt + rx_err_cnt + proto_err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
src/uart_scrambler_pkg.sv
src/baud_tick_gen.sv
src/key_schedule.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_scrambler_top.sv
dv/uart_checker.sv
dv/tb_top.sv

// File: Makefile
# Verilator build and run of the scrambling UART host testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = tb_top
FILELIST = verilog.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
